// ==== hw/soc_pkg.sv ====
package soc_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 64;
    // ram word and instruction width
    localparam int word_w = 32;

    // address map
    localparam logic [addr_w-1:0] ram_base  = 32'h0000_0000;
    localparam logic [addr_w-1:0] plic_base = 32'h0C00_0000;
    // plic window, offsets below this fit in 22 bits
    localparam logic [addr_w-1:0] plic_span = 32'h0040_0000;

    // load kinds, same codes as the core's ls_type
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } ls_kind_e;

    // store kinds reuse the low four codes
    localparam ls_kind_e sb = lb;
    localparam ls_kind_e sh = lh;
    localparam ls_kind_e sw = lw;
    localparam ls_kind_e sd = ld;

endpackage

// ==== hw/plic_pkg.sv ====
package plic_pkg;

    // priority and threshold width
    localparam int prio_w = 3;
    // context 0 is machine mode, context 1 supervisor
    localparam int num_ctx = 2;
    // offset width inside the plic window
    localparam int off_w = 22;

    // per-context strides
    localparam int enable_stride = 32'h80;
    localparam int ctx_stride = 32'h1000;

    // register offsets of context 0; priority adds 4 per source id
    typedef enum logic [off_w-1:0] {
        reg_priority  = 22'h00_0000,
        reg_pending   = 22'h00_1000,
        reg_enable    = 22'h00_2000,
        reg_threshold = 22'h20_0000,
        reg_claim     = 22'h20_0004
    } plic_reg_e;

endpackage

// ==== hw/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder
    import soc_pkg::*;
#(
    parameter int ram_words = 512
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic [addr_w-1:0] wb_adr,
    output logic [data_w-1:0] wb_dat_r,
    output logic              wb_ack,
    output logic              ram_stb,
    input  logic [data_w-1:0] ram_dat_r,
    input  logic              ram_ack,
    output logic              plic_stb,
    input  logic [data_w-1:0] plic_dat_r,
    input  logic              plic_ack
);

    // first address past the ram
    localparam logic [addr_w-1:0] ram_end = ram_base + addr_w'(ram_words * 4);

    logic ram_sel;
    logic plic_sel;
    logic req;
    logic none_ack;

    assign ram_sel  = (wb_adr >= ram_base) && (wb_adr < ram_end);
    assign plic_sel = (wb_adr >= plic_base) && (wb_adr < plic_base + plic_span);
    assign req      = wb_cyc && wb_stb;

    // strobe goes only to the selected target
    assign ram_stb  = req && ram_sel;
    assign plic_stb = req && plic_sel;

    // unmapped address, answer locally after one cycle
    // and skip the cycle where the old stb is still up
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= req && !ram_sel && !plic_sel && !none_ack;
        end
    end

    // return path
    always_comb begin
        if (ram_sel) begin
            wb_ack   = ram_ack;
            wb_dat_r = ram_dat_r;
        end else if (plic_sel) begin
            wb_ack   = plic_ack;
            wb_dat_r = plic_dat_r;
        end else begin
            // unmapped reads return zero
            wb_ack   = none_ack;
            wb_dat_r = '0;
        end
    end

    // a target may only answer an access the master still holds
    a_ack_needs_stb: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        wb_ack |-> wb_stb
    );

endmodule

// ==== hw/ram_arbiter.sv ====
`timescale 1ns/1ps

module ram_arbiter
    import soc_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              data_req,
    output logic              data_done,
    input  logic              fetch_req,
    input  logic [addr_w-1:0] fetch_addr,
    output logic              fetch_done,
    output logic [word_w-1:0] fetch_instr,
    output logic              mem_req,
    output logic              mem_fetch,
    input  logic              mem_done,
    input  logic [word_w-1:0] mem_rdata
);

    typedef enum logic [1:0] {
        gnt_idle,
        gnt_data,
        gnt_fetch
    } gnt_e;

    gnt_e gnt;
    // set when fetch won the last grant
    logic last_fetch;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            gnt        <= gnt_idle;
            last_fetch <= 1'b0;
        end else begin
            case (gnt)
                gnt_idle: begin
                    // on a tie the port not served last goes first
                    if (fetch_req && (!data_req || !last_fetch)) begin
                        gnt        <= gnt_fetch;
                        last_fetch <= 1'b1;
                    end else if (data_req) begin
                        gnt        <= gnt_data;
                        last_fetch <= 1'b0;
                    end
                end
                // grant held until the ram finishes
                gnt_data,
                gnt_fetch: begin
                    if (mem_done) begin
                        gnt <= gnt_idle;
                    end
                end
                default: gnt <= gnt_idle;
            endcase
        end
    end

    assign mem_req   = (gnt != gnt_idle);
    assign mem_fetch = (gnt == gnt_fetch);

    // done goes back to the owner only
    assign data_done  = (gnt == gnt_data) && mem_done;
    assign fetch_done = (gnt == gnt_fetch) && mem_done;

    // instruction bytes come out of ram in the opposite order
    assign fetch_instr = {mem_rdata[7:0], mem_rdata[15:8], mem_rdata[23:16], mem_rdata[31:24]};

    // every ram done reaches exactly one owner
    a_one_owner: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        mem_done |-> (data_done != fetch_done)
    );

    // fetch master holds its address for the whole grant
    a_fetch_addr_held: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        (gnt == gnt_fetch) && !mem_done |=> $stable(fetch_addr)
    );

endmodule

// ==== hw/ram_store.sv ====
`timescale 1ns/1ps

module ram_store
    import soc_pkg::*;
#(
    parameter int ram_words = 512
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              req,
    input  logic              fetch,
    input  logic [addr_w-1:0] fetch_addr,
    input  logic [addr_w-1:0] adr,
    input  logic              we,
    input  ls_kind_e          kind,
    input  logic [data_w-1:0] dat_w,
    output logic [data_w-1:0] dat_r,
    output logic [word_w-1:0] word_out,
    output logic              done
);

    localparam int aw = $clog2(ram_words);

    typedef enum logic {
        beat_first,
        beat_second
    } beat_e;

    logic [word_w-1:0] mem [ram_words];

    beat_e             beat;
    logic [aw-1:0]     idx;
    logic [aw-1:0]     fetch_idx;
    logic              go;
    logic              two_beat;
    logic [word_w-1:0] rd_word;
    logic [word_w-1:0] shifted;
    logic [data_w-1:0] load_ext;

    assign idx       = adr[2 +: aw];
    assign fetch_idx = fetch_addr[2 +: aw];
    // no new access while done is still showing
    assign go        = req && !done;
    // ld and sd share the code
    assign two_beat  = !fetch && (kind == ld);

    // byte lane lands at bit 0
    assign rd_word = mem[idx];
    assign shifted = rd_word >> {adr[1:0], 3'b000};

    always_comb begin
        case (kind)
            lb:      load_ext = {{56{shifted[7]}}, shifted[7:0]};
            lh:      load_ext = {{48{shifted[15]}}, shifted[15:0]};
            lw:      load_ext = {{32{rd_word[31]}}, rd_word};
            lbu:     load_ext = {56'd0, shifted[7:0]};
            lhu:     load_ext = {48'd0, shifted[15:0]};
            // lwu, and the low half of ld
            default: load_ext = {32'd0, rd_word};
        endcase
    end

    // beat sequencing and done pulse
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat <= beat_first;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (go) begin
                if (two_beat && beat == beat_first) begin
                    beat <= beat_second;
                end else begin
                    beat <= beat_first;
                    done <= 1'b1;
                end
            end
        end
    end

    // array and read data
    always_ff @(posedge CLOCK_50) begin
        if (go) begin
            if (fetch) begin
                word_out <= mem[fetch_idx];
            end else if (we) begin
                case (kind)
                    sb: mem[idx][{adr[1:0], 3'b000} +: 8] <= dat_w[7:0];
                    sh: mem[idx][{adr[1], 4'b0000} +: 16] <= dat_w[15:0];
                    sw: mem[idx] <= dat_w[31:0];
                    sd: begin
                        // low word first, high word at the next address
                        if (beat == beat_first) begin
                            mem[idx] <= dat_w[31:0];
                        end else begin
                            mem[idx + 1'b1] <= dat_w[63:32];
                        end
                    end
                    default: ;
                endcase
            end else if (beat == beat_second) begin
                dat_r[63:32] <= mem[idx + 1'b1];
            end else begin
                dat_r <= load_ext;
            end
        end
    end

    // second beat still belongs to a granted ld or sd
    a_second_after_double: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        (beat == beat_second) |-> (req && !fetch && kind == ld)
    );

endmodule

// ==== hw/plic.sv ====
`timescale 1ns/1ps

module plic
    import soc_pkg::*;
    import plic_pkg::*;
#(
    parameter int num_src = 5
) (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              stb,
    input  logic              we,
    input  logic [addr_w-1:0] adr,
    input  logic [data_w-1:0] dat_w,
    output logic [data_w-1:0] dat_r,
    output logic              ack,
    input  logic [num_src-1:0] irq_src,
    output logic              meip,
    output logic              seip
);

    localparam int id_w = $clog2(num_src + 1);

    // bit 0 of pending and enable stays zero, id 0 means no interrupt
    logic [prio_w-1:0]  prio [1:num_src];
    logic [num_src:0]   pending;
    logic [num_src:0]   enable [num_ctx];
    logic [prio_w-1:0]  threshold [num_ctx];
    logic [id_w-1:0]    claim_id [num_ctx];

    logic [off_w-1:0]   off;
    logic [off_w-1:0]   prio_off;
    logic [9:0]         prio_id;
    logic               prio_hit;
    logic               access;
    logic [data_w-1:0]  rd_val;

    assign off      = off_w'(adr - plic_base);
    assign prio_off = off - reg_priority;
    assign prio_id  = prio_off[11:2];
    // valid source ids only
    assign prio_hit = (off < reg_pending) && (prio_id != 0) && (prio_id <= num_src);
    assign access   = stb && !ack;

    // best enabled pending source above threshold, lower id wins a tie
    always_comb begin
        logic [prio_w-1:0] best;
        for (int c = 0; c < num_ctx; c++) begin
            best        = threshold[c];
            claim_id[c] = '0;
            for (int s = 1; s <= num_src; s++) begin
                if (pending[s] && enable[c][s] && prio[s] > best) begin
                    best        = prio[s];
                    claim_id[c] = id_w'(s);
                end
            end
        end
    end

    assign meip = (claim_id[0] != 0);
    assign seip = (claim_id[1] != 0);

    // read mux
    always_comb begin
        rd_val = '0;
        if (prio_hit) begin
            rd_val = data_w'(prio[prio_id]);
        end else if (off == reg_pending) begin
            rd_val = data_w'(pending);
        end
        for (int c = 0; c < num_ctx; c++) begin
            if (off == reg_enable + off_w'(c * enable_stride)) begin
                rd_val = data_w'(enable[c]);
            end
            if (off == reg_threshold + off_w'(c * ctx_stride)) begin
                rd_val = data_w'(threshold[c]);
            end
            if (off == reg_claim + off_w'(c * ctx_stride)) begin
                rd_val = data_w'(claim_id[c]);
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ack     <= 1'b0;
            pending <= '0;
            for (int s = 1; s <= num_src; s++) begin
                prio[s] <= '0;
            end
            for (int c = 0; c < num_ctx; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            // one ack per access
            ack     <= access;
            // level sources keep setting their bit
            pending <= pending | {irq_src, 1'b0};
            if (access && we) begin
                if (prio_hit) begin
                    prio[prio_id] <= dat_w[prio_w-1:0];
                end
                for (int c = 0; c < num_ctx; c++) begin
                    if (off == reg_enable + off_w'(c * enable_stride)) begin
                        enable[c] <= {dat_w[num_src:1], 1'b0};
                    end
                    if (off == reg_threshold + off_w'(c * ctx_stride)) begin
                        threshold[c] <= dat_w[prio_w-1:0];
                    end
                end
            end else if (access) begin
                // claim read takes the source off pending
                for (int c = 0; c < num_ctx; c++) begin
                    if (off == reg_claim + off_w'(c * ctx_stride)) begin
                        pending[claim_id[c]] <= 1'b0;
                    end
                end
            end
        end
    end

    // read data
    always_ff @(posedge CLOCK_50) begin
        if (access && !we) begin
            dat_r <= rd_val;
        end
    end

endmodule

// ==== hw/soc_top.sv ====
`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
#(
    parameter int ram_words = 512,
    parameter int num_src   = 5
) (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [addr_w-1:0]  wb_adr,
    input  logic [data_w-1:0]  wb_dat_w,
    input  ls_kind_e           wb_kind,
    output logic [data_w-1:0]  wb_dat_r,
    output logic               wb_ack,
    input  logic               fetch_req,
    input  logic [addr_w-1:0]  fetch_addr,
    output logic [word_w-1:0]  fetch_instr,
    output logic               fetch_ack,
    input  logic [num_src-1:0] irq_src,
    output logic               meip,
    output logic               seip
);

    // data port to targets
    logic              ram_stb;
    logic              ram_ack;
    logic [data_w-1:0] ram_dat_r;
    logic              plic_stb;
    logic              plic_ack;
    logic [data_w-1:0] plic_dat_r;
    // arbiter to ram
    logic              mem_req;
    logic              mem_fetch;
    logic              mem_done;
    logic [word_w-1:0] mem_rdata;

    bus_decoder #(
        .ram_words (ram_words)
    ) u_bus_decoder (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .ram_stb    (ram_stb),
        .ram_dat_r  (ram_dat_r),
        .ram_ack    (ram_ack),
        .plic_stb   (plic_stb),
        .plic_dat_r (plic_dat_r),
        .plic_ack   (plic_ack)
    );

    ram_arbiter u_ram_arbiter (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .data_req    (ram_stb),
        .data_done   (ram_ack),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_done  (fetch_ack),
        .fetch_instr (fetch_instr),
        .mem_req     (mem_req),
        .mem_fetch   (mem_fetch),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rdata)
    );

    // data fields reach the ram without passing the arbiter
    ram_store #(
        .ram_words (ram_words)
    ) u_ram_store (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (mem_req),
        .fetch      (mem_fetch),
        .fetch_addr (fetch_addr),
        .adr        (wb_adr),
        .we         (wb_we),
        .kind       (wb_kind),
        .dat_w      (wb_dat_w),
        .dat_r      (ram_dat_r),
        .word_out   (mem_rdata),
        .done       (mem_done)
    );

    plic #(
        .num_src (num_src)
    ) u_plic (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .stb      (plic_stb),
        .we       (wb_we),
        .adr      (wb_adr),
        .dat_w    (wb_dat_w),
        .dat_r    (plic_dat_r),
        .ack      (plic_ack),
        .irq_src  (irq_src),
        .meip     (meip),
        .seip     (seip)
    );

endmodule

// ==== bench/tb_soc.sv ====
`timescale 1ns/1ps

module tb_soc
    import soc_pkg::*;
();

    localparam int ram_words = 512;
    localparam int num_src   = 5;
    // fetch traffic runs beside the table
    localparam int n_fetch   = 12;
    localparam int n_code    = 8;
    localparam logic [addr_w-1:0] code_base = 32'h0000_0100;

    typedef enum logic [1:0] {
        op_write,
        op_read,
        op_irq
    } op_e;

    // one access, or one irq pulse with the source bits in wdata
    typedef struct packed {
        op_e               op;
        logic [addr_w-1:0] adr;
        ls_kind_e          kind;
        logic [data_w-1:0] wdata;
        logic [data_w-1:0] rdata;
        logic              meip;
        logic              seip;
    } entry_t;

    logic               CLOCK_50;
    logic               KEY0;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [addr_w-1:0]  wb_adr;
    logic [data_w-1:0]  wb_dat_w;
    ls_kind_e           wb_kind;
    logic [data_w-1:0]  wb_dat_r;
    logic               wb_ack;
    logic               fetch_req;
    logic [addr_w-1:0]  fetch_addr;
    logic [word_w-1:0]  fetch_instr;
    logic               fetch_ack;
    logic [num_src-1:0] irq_src;
    logic               meip;
    logic               seip;

    entry_t stim[$];
    // small program placed at code_base, never written again
    logic [word_w-1:0] code_words [n_code] = '{
        32'h0050_0093, 32'h00a0_0113, 32'h0020_81b3, 32'h4020_8233,
        32'h0000_006f, 32'hfe01_0113, 32'h0011_2e23, 32'h0000_8067
    };
    integer seed        = 56;
    int     cycle_count = 0;
    int     cycle_limit = 0;
    int     check_count = 0;
    int     fail_count  = 0;
    int     fetch_count = 0;
    logic   code_ready  = 1'b0;

    soc_top #(
        .ram_words (ram_words),
        .num_src   (num_src)
    ) u_dut (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_kind     (wb_kind),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .fetch_ack   (fetch_ack),
        .irq_src     (irq_src),
        .meip        (meip),
        .seip        (seip)
    );

    // 40 ns clock
    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
    end

    // watchdog, limit set once the table is built
    initial begin
        wait (cycle_limit > 0);
        wait (cycle_count >= cycle_limit);
        $display("timeout: the bus stopped answering after %0d cycles", cycle_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic void add_entry(input op_e op, input logic [addr_w-1:0] adr,
                                      input ls_kind_e kind, input logic [data_w-1:0] wdata,
                                      input logic [data_w-1:0] rdata, input logic m,
                                      input logic s);
        entry_t e;
        e.op    = op;
        e.adr   = adr;
        e.kind  = kind;
        e.wdata = wdata;
        e.rdata = rdata;
        e.meip  = m;
        e.seip  = s;
        stim.push_back(e);
    endfunction

    function automatic void add_write(input logic [addr_w-1:0] adr, input ls_kind_e kind,
                                      input logic [data_w-1:0] wdata, input logic m,
                                      input logic s);
        add_entry(op_write, adr, kind, wdata, 64'd0, m, s);
    endfunction

    function automatic void add_read(input logic [addr_w-1:0] adr, input ls_kind_e kind,
                                     input logic [data_w-1:0] rdata, input logic m,
                                     input logic s);
        add_entry(op_read, adr, kind, 64'd0, rdata, m, s);
    endfunction

    function automatic void add_irq(input logic [num_src-1:0] bits, input logic m,
                                    input logic s);
        add_entry(op_irq, 32'd0, lw, data_w'(bits), 64'd0, m, s);
    endfunction

    // first byte in memory becomes the top byte of the instruction
    function automatic logic [word_w-1:0] swap_bytes(input logic [word_w-1:0] w);
        logic [word_w-1:0] r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = w[8*(3-b) +: 8];
        end
        return r;
    endfunction

    task automatic check_data(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                              input string what);
        check_count++;
        if (got !== exp) begin
            fail_count++;
            $display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_irq(input logic got_m, input logic got_s, input logic exp_m,
                             input logic exp_s, input string what);
        check_count++;
        if (got_m !== exp_m || got_s !== exp_s) begin
            fail_count++;
            $display("FAIL %0t: %s meip/seip %b%b, expected %b%b",
                     $time, what, got_m, got_s, exp_m, exp_s);
        end
    endtask

    task automatic check_instr(input logic [word_w-1:0] got, input logic [word_w-1:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            fail_count++;
            $display("FAIL %0t: %s instr %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic build_table();
        // code region for the fetch port
        for (int i = 0; i < n_code; i++) begin
            add_write(code_base + 32'(i * 4), sw, data_w'(code_words[i]), 1'b0, 1'b0);
        end
        // word store, then every load kind on it
        add_write(32'h0000_0010, sw, 64'hFFFF_0000_8765_A3C1, 1'b0, 1'b0);
        add_read(32'h0000_0010, lw,  64'hFFFF_FFFF_8765_A3C1, 1'b0, 1'b0);
        add_read(32'h0000_0010, lwu, 64'h0000_0000_8765_A3C1, 1'b0, 1'b0);
        add_read(32'h0000_0010, lh,  64'hFFFF_FFFF_FFFF_A3C1, 1'b0, 1'b0);
        add_read(32'h0000_0012, lh,  64'hFFFF_FFFF_FFFF_8765, 1'b0, 1'b0);
        add_read(32'h0000_0012, lhu, 64'h0000_0000_0000_8765, 1'b0, 1'b0);
        add_read(32'h0000_0010, lb,  64'hFFFF_FFFF_FFFF_FFC1, 1'b0, 1'b0);
        add_read(32'h0000_0012, lb,  64'h0000_0000_0000_0065, 1'b0, 1'b0);
        add_read(32'h0000_0011, lbu, 64'h0000_0000_0000_00A3, 1'b0, 1'b0);
        // doubleword, low word at the lower address
        add_write(32'h0000_0020, sd, 64'h0123_4567_89AB_CDEF, 1'b0, 1'b0);
        add_read(32'h0000_0020, ld,  64'h0123_4567_89AB_CDEF, 1'b0, 1'b0);
        add_read(32'h0000_0024, lw,  64'h0000_0000_0123_4567, 1'b0, 1'b0);
        add_read(32'h0000_0020, lw,  64'hFFFF_FFFF_89AB_CDEF, 1'b0, 1'b0);
        // byte lanes, upper write bits must be ignored
        add_write(32'h0000_0030, sw, 64'h0000_0000_1122_3344, 1'b0, 1'b0);
        add_write(32'h0000_0030, sb, 64'hFFFF_FFFF_FFFF_FFAA, 1'b0, 1'b0);
        add_read(32'h0000_0030, lw,  64'h0000_0000_1122_33AA, 1'b0, 1'b0);
        add_write(32'h0000_0033, sb, 64'hFFFF_FFFF_FFFF_FFDD, 1'b0, 1'b0);
        add_read(32'h0000_0030, lw,  64'hFFFF_FFFF_DD22_33AA, 1'b0, 1'b0);
        add_write(32'h0000_0031, sb, 64'hFFFF_FFFF_FFFF_FFBB, 1'b0, 1'b0);
        add_read(32'h0000_0030, lw,  64'hFFFF_FFFF_DD22_BBAA, 1'b0, 1'b0);
        add_write(32'h0000_0032, sb, 64'hFFFF_FFFF_FFFF_FFCC, 1'b0, 1'b0);
        add_read(32'h0000_0030, lw,  64'hFFFF_FFFF_DDCC_BBAA, 1'b0, 1'b0);
        add_write(32'h0000_0032, sh, 64'hFFFF_FFFF_FFFF_5566, 1'b0, 1'b0);
        add_read(32'h0000_0030, lw,  64'h0000_0000_5566_BBAA, 1'b0, 1'b0);
        // unmapped, 0x810 would alias word 4 if it leaked into the ram
        add_read(32'h0000_0810, lw,  64'd0, 1'b0, 1'b0);
        add_write(32'h0000_0810, sw, 64'h0000_0000_DEAD_BEEF, 1'b0, 1'b0);
        add_read(32'h0000_0010, lwu, 64'h0000_0000_8765_A3C1, 1'b0, 1'b0);
        add_read(32'h1000_0000, lw,  64'd0, 1'b0, 1'b0);
        // plic, priority 2 = 3 and 4 = 5, threshold 4, enable 2 and 4
        add_write(32'h0C00_0008, sw, 64'd3, 1'b0, 1'b0);
        add_write(32'h0C00_0010, sw, 64'd5, 1'b0, 1'b0);
        add_write(32'h0C20_0000, sw, 64'd4, 1'b0, 1'b0);
        add_write(32'h0C00_2000, sw, 64'h14, 1'b0, 1'b0);
        // source 2 stays below the threshold
        add_irq(5'b00010, 1'b0, 1'b0);
        add_read(32'h0C00_1000, lw, 64'h04, 1'b0, 1'b0);
        add_irq(5'b01000, 1'b1, 1'b0);
        add_read(32'h0C20_0004, lw, 64'd4, 1'b0, 1'b0);
        // lower threshold lets source 2 through
        add_write(32'h0C20_0000, sw, 64'd2, 1'b1, 1'b0);
        add_read(32'h0C20_0004, lw, 64'd2, 1'b0, 1'b0);
        // equal priorities, lower id first
        add_write(32'h0C00_0004, sw, 64'd6, 1'b0, 1'b0);
        add_write(32'h0C00_000C, sw, 64'd6, 1'b0, 1'b0);
        add_write(32'h0C00_2000, sw, 64'h0A, 1'b0, 1'b0);
        add_irq(5'b00101, 1'b1, 1'b0);
        add_read(32'h0C20_0004, lw, 64'd1, 1'b1, 1'b0);
        add_read(32'h0C20_0004, lw, 64'd3, 1'b0, 1'b0);
        // source 5 only reaches context 1
        add_write(32'h0C00_0014, sw, 64'd1, 1'b0, 1'b0);
        add_irq(5'b10000, 1'b0, 1'b0);
        add_write(32'h0C00_2080, sw, 64'h20, 1'b0, 1'b1);
        add_write(32'h0C00_2080, sw, 64'h00, 1'b0, 1'b0);
        add_write(32'h0C00_2080, sw, 64'h20, 1'b0, 1'b1);
        add_read(32'h0C20_1004, lw, 64'd5, 1'b0, 1'b0);
    endtask

    task automatic run_entry(input entry_t e, input int n);
        int    fails_before;
        string what;
        fails_before = fail_count;
        what         = $sformatf("entry %0d at %h", n, e.adr);
        @(posedge CLOCK_50);
        #2;
        if (e.op == op_irq) begin
            // one-cycle pulse, pending holds it
            irq_src = e.wdata[num_src-1:0];
            @(posedge CLOCK_50);
            #2;
            irq_src = '0;
            @(negedge CLOCK_50);
        end else begin
            wb_cyc   = 1'b1;
            wb_stb   = 1'b1;
            wb_we    = (e.op == op_write);
            wb_adr   = e.adr;
            wb_dat_w = e.wdata;
            wb_kind  = e.kind;
            @(negedge CLOCK_50);
            while (!wb_ack) @(negedge CLOCK_50);
            if (e.op == op_read) begin
                check_data(wb_dat_r, e.rdata, what);
            end
        end
        check_irq(meip, seip, e.meip, e.seip, what);
        // release the bus after the ack cycle
        @(posedge CLOCK_50);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        if (fail_count == fails_before) begin
            $display("%s ok", what);
        end
    endtask

    // fetch master, random words of the code region
    initial begin
        int idx;
        wait (code_ready);
        for (int k = 0; k < n_fetch; k++) begin
            idx = $unsigned($random(seed)) % n_code;
            @(posedge CLOCK_50);
            #2;
            fetch_req  = 1'b1;
            fetch_addr = code_base + 32'(idx * 4);
            @(negedge CLOCK_50);
            while (!fetch_ack) @(negedge CLOCK_50);
            check_instr(fetch_instr, swap_bytes(code_words[idx]), $sformatf("fetch %0d", k));
            @(posedge CLOCK_50);
            #2;
            fetch_req = 1'b0;
            $display("fetch %0d from %h done", k, fetch_addr);
            fetch_count++;
        end
    end

    initial begin
        KEY0       = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_kind    = lw;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        irq_src    = '0;
        build_table();
        cycle_limit = stim.size() * 20 + n_fetch * 10;
        repeat (2) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;
        check_irq(meip, seip, 1'b0, 1'b0, "after reset");
        for (int i = 0; i < stim.size(); i++) begin
            run_entry(stim[i], i);
            // fetches start once the code words are in
            if (i == n_code - 1) begin
                code_ready = 1'b1;
            end
        end
        wait (fetch_count == n_fetch);
        $display("%0d checks, %0d failures", check_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hw/soc_pkg.sv
hw/plic_pkg.sv
hw/bus_decoder.sv
hw/ram_arbiter.sv
hw/ram_store.sv
hw/plic.sv
hw/soc_top.sv
bench/tb_soc.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_soc
FLIST     := flist.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "result: fail"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "result: no pass line"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
